/* list.f */
+incdir+.
isa_pkg.sv
sb_pkg.sv
regfile.sv
scoreboard.sv
issue_read_operands.sv
issue_stage.sv
tb_issue_stage.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module tb_issue_stage
	verilator --lint-only -f list.f --top-module issue_stage

sim:
	verilator --binary -f list.f --top-module tb_issue_stage -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "\*\* FAIL \*\*" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "\*\* PASS \*\*" sim.log; then echo "No pass message"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* tb_issue_stage.sv */
`timescale 1ns/1ps
`include "issue_settings.svh"

module tb_issue_stage;
  import isa_pkg::*;
  import sb_pkg::*;

  localparam int NUM_ROWS  = 22;
  localparam int MAX_CYCLE = 40 * NUM_ROWS;

  logic clk_i = 1'b0;
  logic rst_i, flush_i, flush_unissued_instr_i;
  logic decoded_valid_i, decoded_use_imm_i, decoded_ack_o;
  fu_t decoded_fu_i;
  op_t decoded_op_i;
  reg_addr_t decoded_rd_i, decoded_rs1_i, decoded_rs2_i;
  imm_t decoded_imm_i;
  logic sb_full_o, stall_issue_o, flu_ready_i, lsu_ready_i;
  logic alu_valid_o, mult_valid_o, lsu_valid_o;
  op_t op_o;
  xlen_t operand_a_o, operand_b_o, wb_data_i, commit_data_o, wdata_i;
  trans_id_t trans_id_o, wb_trans_id_i, commit_trans_id_o;
  logic wb_valid_i, commit_valid_o, commit_ack_i, we_i;
  reg_addr_t commit_rd_o, waddr_i;

  issue_stage dut (.*);

  always #2 clk_i = ~clk_i;

  // Commit stage writes the head result straight back
  assign we_i    = commit_valid_o & commit_ack_i;
  assign waddr_i = commit_rd_o;
  assign wdata_i = commit_data_o;

  // Instruction table where flush rows carry no instruction
  fu_t tbl_fu [NUM_ROWS];
  op_t tbl_op [NUM_ROWS];
  reg_addr_t tbl_rd [NUM_ROWS], tbl_rs1 [NUM_ROWS], tbl_rs2 [NUM_ROWS];
  logic tbl_use_imm [NUM_ROWS], tbl_flush [NUM_ROWS];
  imm_t tbl_imm [NUM_ROWS];
  int n_rows = 0;

  // Speculative model at decode and architectural model at commit
  xlen_t spec_rf [`ISS_NR_REGS];
  xlen_t arch_rf [`ISS_NR_REGS];
  fu_t cur_fu;
  op_t cur_op;
  xlen_t cur_a, cur_b, cur_res;
  reg_addr_t cur_rd;

  // Expected FU pulses and commits in program order
  fu_t exp_fu_q[$];
  op_t exp_op_q[$];
  xlen_t exp_a_q[$], exp_b_q[$], exp_res_q[$];
  trans_id_t exp_id_q[$], exp_cid_q[$];
  reg_addr_t exp_rd_q[$];

  // Pending writebacks of the FU model
  trans_id_t wb_id_q[$];
  xlen_t wb_data_q[$];
  int wb_due_q[$];

  integer seed = 47;
  int cycle_cnt = 0;
  int last_due = 0;
  trans_id_t alloc_id = '0;
  logic prev_flu = 1'b1;
  logic prev_lsu = 1'b1;
  logic full_seen = 1'b0;
  logic stall_seen = 1'b0;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_xlen(input string what, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_reg(input string what, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s got x%0d expected x%0d", $time, what, got, exp));
    end
  endtask

  task automatic check_id(input string what, input trans_id_t got, input trans_id_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_op(input op_t got, input op_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: op got %s expected %s", $time, got.name(), exp.name()));
    end
  endtask

  task automatic check_fu(input fu_t got, input fu_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL at %0t: unit got %s expected %s", $time, got.name(), exp.name()));
    end
  endtask

  // Signed value of the raw immediate widened to a data word
  function automatic xlen_t sext_imm(input imm_t imm);
    int value;
    value = $signed(imm);
    return xlen_t'(value);
  endfunction

  // Load data is a fixed pattern over the whole address
  function automatic xlen_t calc_result(input op_t op, input xlen_t a, input xlen_t b);
    xlen_t addr;
    addr = a + b;
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_MUL:  return a * b;
      OP_LOAD: return {addr[15:0] ^ 16'h5a5a, addr[31:16] ^ addr[15:0]};
      default: return b;
    endcase
  endfunction

  task automatic add_row(input fu_t fu, input op_t op, input int rd, input int rs1,
                         input int rs2, input logic use_imm, input int imm, input logic fl);
    tbl_fu[n_rows]      = fu;
    tbl_op[n_rows]      = op;
    tbl_rd[n_rows]      = reg_addr_t'(rd);
    tbl_rs1[n_rows]     = reg_addr_t'(rs1);
    tbl_rs2[n_rows]     = reg_addr_t'(rs2);
    tbl_use_imm[n_rows] = use_imm;
    tbl_imm[n_rows]     = imm_t'(imm);
    tbl_flush[n_rows]   = fl;
    n_rows++;
  endtask

  task automatic build_table();
    add_row(FU_ALU,  OP_ADD,   1, 0, 0, 1, 5, 0);
    add_row(FU_ALU,  OP_ADD,   2, 0, 0, 1, 'hffd, 0);
    // Back to back RAW chain
    add_row(FU_ALU,  OP_ADD,   3, 1, 2, 0, 0, 0);
    add_row(FU_MULT, OP_MUL,   4, 3, 1, 0, 0, 0);
    add_row(FU_ALU,  OP_SUB,   5, 4, 3, 0, 0, 0);
    add_row(FU_ALU,  OP_OR,    6, 5, 0, 1, 'h0f0, 0);
    add_row(FU_LSU,  OP_LOAD,  7, 6, 0, 1, 8, 0);
    add_row(FU_ALU,  OP_AND,   8, 7, 1, 0, 0, 0);
    // Write to x0, then read it back
    add_row(FU_ALU,  OP_ADD,   0, 1, 0, 1, 100, 0);
    add_row(FU_ALU,  OP_ADD,   9, 0, 0, 0, 0, 0);
    add_row(FU_MULT, OP_MUL,  10, 9, 2, 0, 0, 0);
    add_row(FU_LSU,  OP_STORE, 0, 1, 3, 0, 0, 0);
    add_row(FU_ALU,  OP_ADD,   1, 1, 1, 0, 0, 0);
    add_row(FU_ALU,  OP_ADD,   1, 1, 0, 1, 1, 0);
    add_row(FU_MULT, OP_MUL,  11, 1, 1, 0, 0, 0);
    add_row(FU_NONE, OP_ADD,   0, 0, 0, 0, 0, 1);
    // Reads after the flush see committed values only
    add_row(FU_ALU,  OP_ADD,  12, 1, 11, 0, 0, 0);
    add_row(FU_ALU,  OP_SUB,  13, 12, 4, 0, 0, 0);
    add_row(FU_LSU,  OP_LOAD, 14, 13, 0, 1, 'hff0, 0);
    add_row(FU_MULT, OP_MUL,  15, 14, 14, 0, 0, 0);
    add_row(FU_ALU,  OP_AND,  16, 15, 12, 0, 0, 0);
    add_row(FU_ALU,  OP_ADD,  17, 16, 0, 0, 0, 0);
  endtask

  // ----------------------------------------
  // Clock edge side with FU model, ready and commit ack
  // ----------------------------------------

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > MAX_CYCLE) begin
      stop_run("Timeout: the scoreboard did not drain in time");
    end
    if (rst_i) begin
      wb_valid_i   <= 1'b0;
      commit_ack_i <= 1'b0;
    end else begin
      flu_ready_i  <= ($random(seed) & 3) != 0;
      lsu_ready_i  <= ($random(seed) & 3) != 0;
      // Commit held off early so the scoreboard fills
      commit_ack_i <= cycle_cnt > 14 && ($random(seed) & 3) != 0;
      if (wb_due_q.size() > 0 && wb_due_q[0] <= cycle_cnt) begin
        wb_valid_i    <= 1'b1;
        wb_trans_id_i <= wb_id_q.pop_front();
        wb_data_i     <= wb_data_q.pop_front();
        void'(wb_due_q.pop_front());
      end else begin
        wb_valid_i <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Mid-cycle monitor
  // ----------------------------------------

  always @(negedge clk_i) begin
    fu_t  got_fu;
    int   delay;
    if (!rst_i) begin
      // Occupancy is the number of decoded rows not yet committed
      check_flag("scoreboard full", sb_full_o, exp_rd_q.size() == `ISS_NR_SB_ENTRIES);
      if (commit_valid_o && commit_ack_i) begin
        if (exp_rd_q.size() == 0) begin
          stop_run("Commit seen with no instruction left to commit");
        end
        check_reg("commit rd", commit_rd_o, exp_rd_q[0]);
        check_xlen("commit data", commit_data_o, exp_res_q[0]);
        check_id("commit id", commit_trans_id_o, exp_cid_q[0]);
        if (exp_rd_q[0] != '0) begin
          arch_rf[exp_rd_q[0]] = exp_res_q[0];
        end
        void'(exp_rd_q.pop_front());
        void'(exp_res_q.pop_front());
        void'(exp_cid_q.pop_front());
      end
      if ((alu_valid_o || mult_valid_o || lsu_valid_o) && !flush_i) begin
        if (32'(alu_valid_o) + 32'(mult_valid_o) + 32'(lsu_valid_o) > 1) begin
          stop_run("More than one functional unit pulsed in one cycle");
        end
        if (exp_fu_q.size() == 0) begin
          stop_run("FU pulse seen with no instruction waiting to issue");
        end
        got_fu = alu_valid_o ? FU_ALU : (mult_valid_o ? FU_MULT : FU_LSU);
        if ((got_fu == FU_LSU && !prev_lsu) || (got_fu != FU_LSU && !prev_flu)) begin
          stop_run("Instruction issued to a unit that was not ready");
        end
        check_fu(got_fu, exp_fu_q.pop_front());
        check_op(op_o, exp_op_q.pop_front());
        check_xlen("operand a", operand_a_o, exp_a_q.pop_front());
        check_xlen("operand b", operand_b_o, exp_b_q.pop_front());
        check_id("issue id", trans_id_o, exp_id_q.pop_front());
        // One writeback per cycle in issue order
        delay    = $unsigned($random(seed)) % 4;
        last_due = (last_due + 1 > cycle_cnt + 1 + delay) ? last_due + 1
                                                          : cycle_cnt + 1 + delay;
        wb_id_q.push_back(trans_id_o);
        wb_data_q.push_back(calc_result(op_o, operand_a_o, operand_b_o));
        wb_due_q.push_back(last_due);
      end
      // Oldest row still waiting is the one offered for issue this cycle
      if (flush_i || exp_fu_q.size() == 0) begin
        check_flag("issue stall", stall_issue_o, 1'b0);
      end else if ((exp_fu_q[0] == FU_LSU) ? !lsu_ready_i : !flu_ready_i) begin
        check_flag("issue stall", stall_issue_o, 1'b1);
      end
      if (sb_full_o) begin
        full_seen = 1'b1;
        if (decoded_ack_o) begin
          stop_run("Decode accepted while the scoreboard was full");
        end
      end
      if (stall_issue_o) begin
        stall_seen = 1'b1;
      end
      if (decoded_ack_o) begin
        exp_fu_q.push_back(cur_fu);
        exp_op_q.push_back(cur_op);
        exp_a_q.push_back(cur_a);
        exp_b_q.push_back(cur_b);
        exp_id_q.push_back(alloc_id);
        exp_cid_q.push_back(alloc_id);
        exp_rd_q.push_back(cur_rd);
        exp_res_q.push_back(cur_res);
        alloc_id = alloc_id + trans_id_t'(1);
      end
      // Flushed rows vanish and decode restarts from committed state
      if (flush_i) begin
        spec_rf = arch_rf;
        exp_fu_q.delete();
        exp_op_q.delete();
        exp_a_q.delete();
        exp_b_q.delete();
        exp_id_q.delete();
        exp_cid_q.delete();
        exp_rd_q.delete();
        exp_res_q.delete();
        wb_id_q.delete();
        wb_data_q.delete();
        wb_due_q.delete();
        alloc_id = '0;
      end
    end
    prev_flu = flu_ready_i;
    prev_lsu = lsu_ready_i;
  end

  // ----------------------------------------
  // Decode driver
  // ----------------------------------------

  initial begin
    rst_i = 1'b1;
    flush_i = 1'b0;
    flush_unissued_instr_i = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_fu_i = FU_NONE;
    decoded_op_i = OP_ADD;
    decoded_rd_i = '0;
    decoded_rs1_i = '0;
    decoded_rs2_i = '0;
    decoded_use_imm_i = 1'b0;
    decoded_imm_i = '0;
    flu_ready_i = 1'b1;
    lsu_ready_i = 1'b1;
    wb_valid_i = 1'b0;
    wb_trans_id_i = '0;
    wb_data_i = '0;
    commit_ack_i = 1'b0;
    for (int r = 0; r < `ISS_NR_REGS; r++) begin
      spec_rf[r] = '0;
      arch_rf[r] = '0;
    end
    build_table();
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk_i);
      if (tbl_flush[i]) begin
        decoded_valid_i <= 1'b0;
        flush_i         <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
      end else begin
        cur_fu  = tbl_fu[i];
        cur_op  = tbl_op[i];
        cur_rd  = tbl_rd[i];
        cur_a   = spec_rf[tbl_rs1[i]];
        cur_b   = tbl_use_imm[i] ? sext_imm(tbl_imm[i]) : spec_rf[tbl_rs2[i]];
        cur_res = calc_result(cur_op, cur_a, cur_b);
        if (cur_rd != '0) begin
          spec_rf[cur_rd] = cur_res;
        end
        decoded_valid_i   <= 1'b1;
        decoded_fu_i      <= tbl_fu[i];
        decoded_op_i      <= tbl_op[i];
        decoded_rd_i      <= tbl_rd[i];
        decoded_rs1_i     <= tbl_rs1[i];
        decoded_rs2_i     <= tbl_rs2[i];
        decoded_use_imm_i <= tbl_use_imm[i];
        decoded_imm_i     <= tbl_imm[i];
        do @(negedge clk_i); while (!decoded_ack_o);
      end
    end
    @(posedge clk_i);
    decoded_valid_i <= 1'b0;
    while (exp_rd_q.size() != 0 || exp_fu_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    if (!full_seen || !stall_seen) begin
      $display("Scoreboard never filled or issue never stalled");
      $display("** FAIL **");
    end else begin
      $display("** PASS **");
    end
    $finish;
  end

endmodule

/* issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               flush_i,
  input  logic               flush_unissued_instr_i,
  // Decode handshake
  input  logic               decoded_valid_i,
  input  isa_pkg::fu_t       decoded_fu_i,
  input  isa_pkg::op_t       decoded_op_i,
  input  isa_pkg::reg_addr_t decoded_rd_i,
  input  isa_pkg::reg_addr_t decoded_rs1_i,
  input  isa_pkg::reg_addr_t decoded_rs2_i,
  input  logic               decoded_use_imm_i,
  input  isa_pkg::imm_t      decoded_imm_i,
  output logic               decoded_ack_o,
  // Performance
  output logic               sb_full_o,
  output logic               stall_issue_o,
  // Functional units
  input  logic               flu_ready_i,
  input  logic               lsu_ready_i,
  output logic               alu_valid_o,
  output logic               mult_valid_o,
  output logic               lsu_valid_o,
  output isa_pkg::op_t       op_o,
  output isa_pkg::xlen_t     operand_a_o,
  output isa_pkg::xlen_t     operand_b_o,
  output sb_pkg::trans_id_t  trans_id_o,
  // Writeback
  input  logic               wb_valid_i,
  input  sb_pkg::trans_id_t  wb_trans_id_i,
  input  isa_pkg::xlen_t     wb_data_i,
  // Commit
  output logic               commit_valid_o,
  output isa_pkg::reg_addr_t commit_rd_o,
  output isa_pkg::xlen_t     commit_data_o,
  output sb_pkg::trans_id_t  commit_trans_id_o,
  input  logic               commit_ack_i,
  input  logic               we_i,
  input  isa_pkg::reg_addr_t waddr_i,
  input  isa_pkg::xlen_t     wdata_i
);
  import isa_pkg::*;
  import sb_pkg::*;

  // ----------------------------------------
  // Scoreboard to issue wires
  // ----------------------------------------

  logic      issue_valid_sb_iro;
  fu_t       issue_fu_sb_iro;
  op_t       issue_op_sb_iro;
  reg_addr_t issue_rs1_sb_iro;
  reg_addr_t issue_rs2_sb_iro;
  logic      issue_use_imm_sb_iro;
  imm_t      issue_imm_sb_iro;
  trans_id_t issue_trans_id_sb_iro;
  logic      issue_ack_iro_sb;

  // Lookup request and answer
  reg_addr_t rs1_iro_sb;
  reg_addr_t rs2_iro_sb;
  logic      rs1_clobbered_sb_iro;
  logic      rs1_fwd_valid_sb_iro;
  xlen_t     rs1_fwd_data_sb_iro;
  logic      rs2_clobbered_sb_iro;
  logic      rs2_fwd_valid_sb_iro;
  xlen_t     rs2_fwd_data_sb_iro;

  scoreboard i_scoreboard (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .flush_i           (flush_i),
    .flush_unissued_i  (flush_unissued_instr_i),
    .decoded_valid_i   (decoded_valid_i),
    .decoded_fu_i      (decoded_fu_i),
    .decoded_op_i      (decoded_op_i),
    .decoded_rd_i      (decoded_rd_i),
    .decoded_rs1_i     (decoded_rs1_i),
    .decoded_rs2_i     (decoded_rs2_i),
    .decoded_use_imm_i (decoded_use_imm_i),
    .decoded_imm_i     (decoded_imm_i),
    .decoded_ack_o     (decoded_ack_o),
    .sb_full_o         (sb_full_o),
    .issue_valid_o     (issue_valid_sb_iro),
    .issue_fu_o        (issue_fu_sb_iro),
    .issue_op_o        (issue_op_sb_iro),
    // Destination is not needed for operand read
    .issue_rd_o        (),
    .issue_rs1_o       (issue_rs1_sb_iro),
    .issue_rs2_o       (issue_rs2_sb_iro),
    .issue_use_imm_o   (issue_use_imm_sb_iro),
    .issue_imm_o       (issue_imm_sb_iro),
    .issue_trans_id_o  (issue_trans_id_sb_iro),
    .issue_ack_i       (issue_ack_iro_sb),
    .rs1_i             (rs1_iro_sb),
    .rs2_i             (rs2_iro_sb),
    .rs1_clobbered_o   (rs1_clobbered_sb_iro),
    .rs1_fwd_valid_o   (rs1_fwd_valid_sb_iro),
    .rs1_fwd_data_o    (rs1_fwd_data_sb_iro),
    .rs2_clobbered_o   (rs2_clobbered_sb_iro),
    .rs2_fwd_valid_o   (rs2_fwd_valid_sb_iro),
    .rs2_fwd_data_o    (rs2_fwd_data_sb_iro),
    .wb_valid_i        (wb_valid_i),
    .wb_trans_id_i     (wb_trans_id_i),
    .wb_data_i         (wb_data_i),
    .commit_valid_o    (commit_valid_o),
    .commit_rd_o       (commit_rd_o),
    .commit_data_o     (commit_data_o),
    .commit_trans_id_o (commit_trans_id_o),
    .commit_ack_i      (commit_ack_i)
  );

  // Full flush also drops the pending dispatch pulse
  issue_read_operands i_issue_read_operands (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .issue_valid_i    (issue_valid_sb_iro),
    .issue_fu_i       (issue_fu_sb_iro),
    .issue_op_i       (issue_op_sb_iro),
    .issue_rs1_i      (issue_rs1_sb_iro),
    .issue_rs2_i      (issue_rs2_sb_iro),
    .issue_use_imm_i  (issue_use_imm_sb_iro),
    .issue_imm_i      (issue_imm_sb_iro),
    .issue_trans_id_i (issue_trans_id_sb_iro),
    .issue_ack_o      (issue_ack_iro_sb),
    .rs1_o            (rs1_iro_sb),
    .rs2_o            (rs2_iro_sb),
    .rs1_clobbered_i  (rs1_clobbered_sb_iro),
    .rs1_fwd_valid_i  (rs1_fwd_valid_sb_iro),
    .rs1_fwd_data_i   (rs1_fwd_data_sb_iro),
    .rs2_clobbered_i  (rs2_clobbered_sb_iro),
    .rs2_fwd_valid_i  (rs2_fwd_valid_sb_iro),
    .rs2_fwd_data_i   (rs2_fwd_data_sb_iro),
    .flu_ready_i      (flu_ready_i),
    .lsu_ready_i      (lsu_ready_i),
    .alu_valid_o      (alu_valid_o),
    .mult_valid_o     (mult_valid_o),
    .lsu_valid_o      (lsu_valid_o),
    .op_o             (op_o),
    .operand_a_o      (operand_a_o),
    .operand_b_o      (operand_b_o),
    .trans_id_o       (trans_id_o),
    .stall_issue_o    (stall_issue_o),
    .we_i             (we_i),
    .waddr_i          (waddr_i),
    .wdata_i          (wdata_i)
  );

endmodule

/* issue_read_operands.sv */
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_read_operands (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               flush_i,
  // Entry offered by the scoreboard
  input  logic               issue_valid_i,
  input  isa_pkg::fu_t       issue_fu_i,
  input  isa_pkg::op_t       issue_op_i,
  input  isa_pkg::reg_addr_t issue_rs1_i,
  input  isa_pkg::reg_addr_t issue_rs2_i,
  input  logic               issue_use_imm_i,
  input  isa_pkg::imm_t      issue_imm_i,
  input  sb_pkg::trans_id_t  issue_trans_id_i,
  output logic               issue_ack_o,
  // Operand lookup in the scoreboard
  output isa_pkg::reg_addr_t rs1_o,
  output isa_pkg::reg_addr_t rs2_o,
  input  logic               rs1_clobbered_i,
  input  logic               rs1_fwd_valid_i,
  input  isa_pkg::xlen_t     rs1_fwd_data_i,
  input  logic               rs2_clobbered_i,
  input  logic               rs2_fwd_valid_i,
  input  isa_pkg::xlen_t     rs2_fwd_data_i,
  // Functional units
  input  logic               flu_ready_i,
  input  logic               lsu_ready_i,
  output logic               alu_valid_o,
  output logic               mult_valid_o,
  output logic               lsu_valid_o,
  output isa_pkg::op_t       op_o,
  output isa_pkg::xlen_t     operand_a_o,
  output isa_pkg::xlen_t     operand_b_o,
  output sb_pkg::trans_id_t  trans_id_o,
  output logic               stall_issue_o,
  // Register file write from commit
  input  logic               we_i,
  input  isa_pkg::reg_addr_t waddr_i,
  input  isa_pkg::xlen_t     wdata_i
);
  import isa_pkg::*;

  xlen_t rf_a;
  xlen_t rf_b;
  xlen_t imm_sext;
  xlen_t operand_a;
  xlen_t operand_b;
  logic  raw_hazard;
  logic  fu_ready;

  // ----------------------------------------
  // Operand read
  // ----------------------------------------

  assign rs1_o = issue_rs1_i;
  assign rs2_o = issue_rs2_i;

  regfile i_regfile (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (issue_rs1_i),
    .raddr_b_i (issue_rs2_i),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .we_i      (we_i),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i)
  );

  assign imm_sext = {{(`ISS_XLEN-`ISS_IMM_W){issue_imm_i[`ISS_IMM_W-1]}}, issue_imm_i};

  // Forwarded result wins over the register file when present
  assign operand_a = (rs1_clobbered_i && rs1_fwd_valid_i) ? rs1_fwd_data_i : rf_a;

  always_comb begin
    if (issue_use_imm_i) begin
      operand_b = imm_sext;
    end else if (rs2_clobbered_i && rs2_fwd_valid_i) begin
      operand_b = rs2_fwd_data_i;
    end else begin
      operand_b = rf_b;
    end
  end

  // ----------------------------------------
  // Hazard and unit readiness
  // ----------------------------------------

  // Producer in flight without its result yet
  assign raw_hazard = (rs1_clobbered_i & ~rs1_fwd_valid_i)
                      | (rs2_clobbered_i & ~rs2_fwd_valid_i);

  // ALU and multiplier share the fixed latency ready
  always_comb begin
    case (issue_fu_i)
      FU_ALU,
      FU_MULT: fu_ready = flu_ready_i;
      FU_LSU:  fu_ready = lsu_ready_i;
      default: fu_ready = 1'b1;
    endcase
  end

  assign issue_ack_o   = issue_valid_i & ~raw_hazard & fu_ready;
  assign stall_issue_o = issue_valid_i & ~issue_ack_o;

  // ----------------------------------------
  // Registered dispatch
  // ----------------------------------------

  // One cycle valid pulse per issued entry
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      alu_valid_o  <= 1'b0;
      mult_valid_o <= 1'b0;
      lsu_valid_o  <= 1'b0;
    end else begin
      alu_valid_o  <= issue_ack_o && issue_fu_i == FU_ALU;
      mult_valid_o <= issue_ack_o && issue_fu_i == FU_MULT;
      lsu_valid_o  <= issue_ack_o && issue_fu_i == FU_LSU;
    end
  end

  // Operands held until the next issue
  always_ff @(posedge clk_i) begin
    if (issue_ack_o) begin
      op_o        <= issue_op_i;
      operand_a_o <= operand_a;
      operand_b_o <= operand_b;
      trans_id_o  <= issue_trans_id_i;
    end
  end

endmodule

/* scoreboard.sv */
`timescale 1ns/1ps
`include "issue_settings.svh"

module scoreboard (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               flush_i,
  input  logic               flush_unissued_i,
  // Decode side
  input  logic               decoded_valid_i,
  input  isa_pkg::fu_t       decoded_fu_i,
  input  isa_pkg::op_t       decoded_op_i,
  input  isa_pkg::reg_addr_t decoded_rd_i,
  input  isa_pkg::reg_addr_t decoded_rs1_i,
  input  isa_pkg::reg_addr_t decoded_rs2_i,
  input  logic               decoded_use_imm_i,
  input  isa_pkg::imm_t      decoded_imm_i,
  output logic               decoded_ack_o,
  output logic               sb_full_o,
  // Oldest unissued entry
  output logic               issue_valid_o,
  output isa_pkg::fu_t       issue_fu_o,
  output isa_pkg::op_t       issue_op_o,
  output isa_pkg::reg_addr_t issue_rd_o,
  output isa_pkg::reg_addr_t issue_rs1_o,
  output isa_pkg::reg_addr_t issue_rs2_o,
  output logic               issue_use_imm_o,
  output isa_pkg::imm_t      issue_imm_o,
  output sb_pkg::trans_id_t  issue_trans_id_o,
  input  logic               issue_ack_i,
  // Operand lookup
  input  isa_pkg::reg_addr_t rs1_i,
  input  isa_pkg::reg_addr_t rs2_i,
  output logic               rs1_clobbered_o,
  output logic               rs1_fwd_valid_o,
  output isa_pkg::xlen_t     rs1_fwd_data_o,
  output logic               rs2_clobbered_o,
  output logic               rs2_fwd_valid_o,
  output isa_pkg::xlen_t     rs2_fwd_data_o,
  // Writeback from the functional units
  input  logic               wb_valid_i,
  input  sb_pkg::trans_id_t  wb_trans_id_i,
  input  isa_pkg::xlen_t     wb_data_i,
  // Commit head
  output logic               commit_valid_o,
  output isa_pkg::reg_addr_t commit_rd_o,
  output isa_pkg::xlen_t     commit_data_o,
  output sb_pkg::trans_id_t  commit_trans_id_o,
  input  logic               commit_ack_i
);
  import isa_pkg::*;
  import sb_pkg::*;

  // Per-slot state bits
  logic [`ISS_NR_SB_ENTRIES-1:0] valid_q;
  logic [`ISS_NR_SB_ENTRIES-1:0] issued_q;
  logic [`ISS_NR_SB_ENTRIES-1:0] res_valid_q;

  // Per-slot payload
  fu_t       fu_q      [`ISS_NR_SB_ENTRIES];
  op_t       op_q      [`ISS_NR_SB_ENTRIES];
  reg_addr_t rd_q      [`ISS_NR_SB_ENTRIES];
  reg_addr_t rs1_q     [`ISS_NR_SB_ENTRIES];
  reg_addr_t rs2_q     [`ISS_NR_SB_ENTRIES];
  logic      use_imm_q [`ISS_NR_SB_ENTRIES];
  imm_t      imm_q     [`ISS_NR_SB_ENTRIES];
  xlen_t     result_q  [`ISS_NR_SB_ENTRIES];

  // Oldest entry, oldest unissued entry, next free slot
  trans_id_t head_q;
  trans_id_t issue_q;
  trans_id_t tail_q;

  trans_id_t alloc_ptr;
  logic      full;
  logic      wb_hit;

  // ----------------------------------------
  // Decode acceptance
  // ----------------------------------------

  // Every slot occupied
  assign full          = &valid_q;
  assign sb_full_o     = full;
  assign decoded_ack_o = decoded_valid_i & ~full & ~flush_i;

  // An unissued-only flush frees the slots from the issue pointer on
  assign alloc_ptr = flush_unissued_i ? issue_q : tail_q;

  // ----------------------------------------
  // Issue port
  // ----------------------------------------

  // Nothing issues during a flush cycle
  assign issue_valid_o    = valid_q[issue_q] & ~issued_q[issue_q]
                            & ~flush_i & ~flush_unissued_i;
  assign issue_fu_o       = fu_q[issue_q];
  assign issue_op_o       = op_q[issue_q];
  assign issue_rd_o       = rd_q[issue_q];
  assign issue_rs1_o      = rs1_q[issue_q];
  assign issue_rs2_o      = rs2_q[issue_q];
  assign issue_use_imm_o  = use_imm_q[issue_q];
  assign issue_imm_o      = imm_q[issue_q];
  assign issue_trans_id_o = issue_q;

  // ----------------------------------------
  // Clobber search and forwarding
  // ----------------------------------------

  // Only issued entries are older than the one at the issue pointer
  // Walk oldest to youngest so the youngest match is kept
  function automatic void find_producer(
    input  reg_addr_t rs,
    output logic      clobbered,
    output logic      fwd_valid,
    output xlen_t     fwd_data
  );
    trans_id_t idx;
    clobbered = 1'b0;
    fwd_valid = 1'b0;
    fwd_data  = '0;
    for (int k = 0; k < `ISS_NR_SB_ENTRIES; k++) begin
      idx = head_q + trans_id_t'(k);
      if (valid_q[idx] && issued_q[idx] && rd_q[idx] == rs && rs != '0) begin
        clobbered = 1'b1;
        fwd_valid = res_valid_q[idx];
        fwd_data  = result_q[idx];
      end
    end
  endfunction

  always_comb begin
    find_producer(rs1_i, rs1_clobbered_o, rs1_fwd_valid_o, rs1_fwd_data_o);
    find_producer(rs2_i, rs2_clobbered_o, rs2_fwd_valid_o, rs2_fwd_data_o);
  end

  // ----------------------------------------
  // Writeback and commit head
  // ----------------------------------------

  // Late results for freed slots are dropped
  assign wb_hit = wb_valid_i & valid_q[wb_trans_id_i] & issued_q[wb_trans_id_i];

  assign commit_valid_o    = valid_q[head_q] & res_valid_q[head_q];
  assign commit_rd_o       = rd_q[head_q];
  assign commit_data_o     = result_q[head_q];
  assign commit_trans_id_o = head_q;

  // Slot state and pointers
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q     <= '0;
      issued_q    <= '0;
      res_valid_q <= '0;
      head_q      <= '0;
      issue_q     <= '0;
      tail_q      <= '0;
    end else begin
      // Whole-vector clear first so the per-slot updates below win
      if (flush_unissued_i) begin
        valid_q <= valid_q & issued_q;
        tail_q  <= issue_q;
      end
      if (commit_valid_o && commit_ack_i) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + trans_id_t'(1);
      end
      if (wb_hit) begin
        res_valid_q[wb_trans_id_i] <= 1'b1;
      end
      if (issue_valid_o && issue_ack_i) begin
        issued_q[issue_q] <= 1'b1;
        issue_q           <= issue_q + trans_id_t'(1);
      end
      // New entry at the tail
      if (decoded_ack_o) begin
        valid_q[alloc_ptr]     <= 1'b1;
        issued_q[alloc_ptr]    <= 1'b0;
        res_valid_q[alloc_ptr] <= 1'b0;
        tail_q                 <= alloc_ptr + trans_id_t'(1);
      end
    end
  end

  // Entry fields and results
  always_ff @(posedge clk_i) begin
    if (decoded_ack_o) begin
      fu_q[alloc_ptr]      <= decoded_fu_i;
      op_q[alloc_ptr]      <= decoded_op_i;
      rd_q[alloc_ptr]      <= decoded_rd_i;
      rs1_q[alloc_ptr]     <= decoded_rs1_i;
      rs2_q[alloc_ptr]     <= decoded_rs2_i;
      use_imm_q[alloc_ptr] <= decoded_use_imm_i;
      imm_q[alloc_ptr]     <= decoded_imm_i;
    end
    if (wb_hit) begin
      result_q[wb_trans_id_i] <= wb_data_i;
    end
  end

endmodule

/* regfile.sv */
`timescale 1ns/1ps
`include "issue_settings.svh"

module regfile (
  input  logic               clk_i,
  input  logic               rst_i,
  // Read ports
  input  isa_pkg::reg_addr_t raddr_a_i,
  input  isa_pkg::reg_addr_t raddr_b_i,
  output isa_pkg::xlen_t     rdata_a_o,
  output isa_pkg::xlen_t     rdata_b_o,
  // Commit write port
  input  logic               we_i,
  input  isa_pkg::reg_addr_t waddr_i,
  input  isa_pkg::xlen_t     wdata_i
);
  import isa_pkg::*;

  xlen_t mem_q [`ISS_NR_REGS];

  // x0 is never written so it reads as zero
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `ISS_NR_REGS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule

/* sb_pkg.sv */
`include "issue_settings.svh"

package sb_pkg;

  // Scoreboard slot index
  // Doubles as the transaction id seen by the functional units
  // and as the head, issue and tail pointers inside the buffer
  typedef logic [`ISS_TRANS_ID_W-1:0] trans_id_t;

endpackage

/* isa_pkg.sv */
`include "issue_settings.svh"

package isa_pkg;

  // Register index
  typedef logic [`ISS_REG_ADDR_W-1:0] reg_addr_t;

  // Integer data word
  typedef logic [`ISS_XLEN-1:0] xlen_t;

  // Source immediate that is sign extended at operand read
  typedef logic [`ISS_IMM_W-1:0] imm_t;

  // Target functional unit
  typedef enum logic [1:0] {
    FU_NONE = 2'd0,
    FU_ALU  = 2'd1,
    FU_MULT = 2'd2,
    FU_LSU  = 2'd3
  } fu_t;

  // Operation within the target unit
  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_MUL   = 3'd4,
    OP_LOAD  = 3'd5,
    OP_STORE = 3'd6
  } op_t;

endpackage

/* issue_settings.svh */
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// ----------------------------------------
// Architectural sizes
// ----------------------------------------

// Integer data path width
`define ISS_XLEN 32
// Integer register count
`define ISS_NR_REGS 32
`define ISS_REG_ADDR_W 5

// ----------------------------------------
// Scoreboard sizes
// ----------------------------------------

// In-flight instruction slots as a power of two
`define ISS_NR_SB_ENTRIES 4
`define ISS_TRANS_ID_W 2

// Raw immediate width before sign extension
`define ISS_IMM_W 12

`endif
